//--- build.f
rtl/digit_pkg.sv
rtl/image_scaler.sv
rtl/credit_queue.sv
rtl/dense_hidden.sv
rtl/dense_output.sv
rtl/argmax_select.sv
rtl/digit_predictor.sv
verif/tb_clock.sv
verif/digit_predictor_chk.sv
verif/digit_predictor_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module digit_predictor_tb -f build.f -o digit_sim
	./obj_dir/digit_sim | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- verif/digit_predictor_tb.sv
module digit_predictor_tb
    import digit_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OUT_CREDITS  = 2;
    localparam int IMG_BITS     = IN_SIDE * IN_SIDE;
    // Single 1, stream 8, back-pressure 4, edge 2, reset 2.
    localparam int N_IMAGES     = 17;
    localparam int IMAGE_CYCLES = 900;
    localparam int CYCLE_LIMIT  = N_IMAGES * IMAGE_CYCLES * 2;

    logic                clk;
    logic                rst;
    logic                rst_req;
    logic                in_valid;
    logic [IMG_BITS-1:0] in_image;
    logic                in_credit;
    logic                out_valid;
    logic [3:0]          out_digit;
    logic                out_credit;

    logic [15:0]         lfsr = 16'd28;
    logic [IMG_BITS-1:0] img;
    int                  expected [$];
    int                  credits;
    int                  credit_pulses;
    int                  sent_count;
    int                  got_count;
    int                  held;
    bit                  return_credits;
    bit                  in_reset;
    string               cur_test;
    int                  checks;
    int                  errors;
    int                  test_errors;
    int                  tests_run;
    int                  tests_failed;
    int                  cycles;

    tb_clock i_clock (
        .clk     (clk),
        .rst     (rst),
        .rst_req (rst_req)
    );

    digit_predictor #(.OUT_CREDITS(OUT_CREDITS)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_image   (in_image),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_digit  (out_digit),
        .out_credit (out_credit)
    );

    bind digit_predictor digit_predictor_chk #(.OUT_CREDITS(OUT_CREDITS)) i_chk (
        .clk        (clk),
        .rst        (rst),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_digit  (out_digit),
        .out_credit (out_credit)
    );

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_image(output logic [IMG_BITS-1:0] image);
        for (int i = 0; i < IMG_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            image[i] = lfsr[0];
        end
    endtask

    // Reference model: sampling, hidden sums, ReLU, scores and the lowest-index argmax.
    task automatic run_model(input logic [IMG_BITS-1:0] image, output int digit);
        int hid [N_HID];
        int score [N_OUT];
        int p;
        int acc;
        for (int n = 0; n < N_HID; n++) begin
            hid[n] = 0;
        end
        for (int r = 0; r < OUT_SIDE; r++) begin
            for (int c = 0; c < OUT_SIDE; c++) begin
                p = r * OUT_SIDE + c;
                if (image[src_index(r) * IN_SIDE + src_index(c)]) begin
                    for (int n = 0; n < N_HID; n++) begin
                        hid[n] += int'(w_hidden(n, p));
                    end
                end
            end
        end
        digit = 0;
        for (int d = 0; d < N_OUT; d++) begin
            acc = 0;
            for (int n = 0; n < N_HID; n++) begin
                if (hid[n] > 0) begin
                    acc += int'(w_output(d, n)) * hid[n];
                end
            end
            score[d] = acc;
            if (acc > score[digit]) begin
                digit = d;
            end
        end
    endtask

    task automatic check_value(input string name, input int exp_val, input int act_val);
        checks++;
        if (exp_val != act_val) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    // One cycle: outputs are sampled on the falling edge, then the inputs are driven.
    task automatic step();
        @(negedge clk);
        if (!in_reset) begin
            if (in_credit) begin
                credits++;
                credit_pulses++;
                if (credits > 1) begin
                    errors++;
                    $display("ERROR %s: in_credit returned more credits than images sent",
                             cur_test);
                end
            end
            if (out_valid) begin
                got_count++;
                held++;
                if (expected.size() == 0) begin
                    errors++;
                    $display("ERROR %s: out_valid with no image outstanding", cur_test);
                end else begin
                    check_value(cur_test, expected.pop_front(), int'(out_digit));
                end
            end
        end
        in_valid = 1'b0;
        if (return_credits && held > 0 && !in_reset) begin
            out_credit = 1'b1;
            held--;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic send_with_expected(input logic [IMG_BITS-1:0] image, input int digit);
        while (credits <= 0) begin
            step();
        end
        expected.push_back(digit);
        in_image = image;
        in_valid = 1'b1;
        credits--;
        sent_count++;
        step();
    endtask

    task automatic send_image(input logic [IMG_BITS-1:0] image);
        int digit;
        run_model(image, digit);
        send_with_expected(image, digit);
    endtask

    task automatic wait_results(input int count);
        while (got_count < count) begin
            step();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int base;
        rst_req        = 1'b0;
        in_valid       = 1'b0;
        in_image       = '0;
        out_credit     = 1'b0;
        credits        = 1;
        return_credits = 1'b1;
        in_reset       = 1'b0;
        cur_test       = "startup";
        // Reset may not be asserted yet at time zero.
        wait (rst == 1'b1);
        wait (rst == 1'b0);
        @(negedge clk);

        begin_test("single_image");
        random_image(img);
        send_image(img);
        wait_results(1);
        end_test();

        begin_test("stream");
        for (int i = 0; i < 8; i++) begin
            random_image(img);
            send_image(img);
        end
        wait_results(9);
        end_test();

        begin_test("output_backpressure");
        while (held > 0) begin
            step();
        end
        return_credits = 1'b0;
        base = got_count;
        for (int i = 0; i < 4; i++) begin
            random_image(img);
            send_image(img);
        end
        wait_results(base + OUT_CREDITS);
        // The last image has left the capture slot once its credit is back.
        while (credits == 0) begin
            step();
        end
        repeat (2 * IMAGE_CYCLES) step();
        check_value(cur_test, OUT_CREDITS, got_count - base);
        return_credits = 1'b1;
        wait_results(base + 4);
        end_test();

        begin_test("input_credits");
        check_value(cur_test, sent_count, credit_pulses);
        check_value(cur_test, 1, credits);
        end_test();

        begin_test("edge_images");
        base = got_count;
        // A blank image gives all-zero scores, so the lowest index wins.
        img = '0;
        send_with_expected(img, 0);
        img = '1;
        send_image(img);
        wait_results(base + 2);
        end_test();

        begin_test("reset_midrun");
        random_image(img);
        send_image(img);
        // The hidden layer is partway through this image when reset lands.
        repeat (400) step();
        rst_req  = 1'b1;
        in_reset = 1'b1;
        repeat (10) step();
        rst_req  = 1'b0;
        in_reset = 1'b0;
        expected.delete();
        credits = 1;
        held    = 0;
        repeat (IMAGE_CYCLES) step();
        base = got_count;
        random_image(img);
        send_image(img);
        wait_results(base + 1);
        end_test();

        if (i_dut.i_chk.assert_fails != 0) begin
            errors += i_dut.i_chk.assert_fails;
            $display("ERROR: %0d assertion failures in the checker",
                     i_dut.i_chk.assert_fails);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verif/digit_predictor_chk.sv
module digit_predictor_chk #(
    parameter int OUT_CREDITS = 2
) (
    input logic       clk,
    input logic       rst,
    input logic       in_credit,
    input logic       out_valid,
    input logic [3:0] out_digit,
    input logic       out_credit
);

    timeunit 1ns;
    timeprecision 1ps;

    // Results sent to the sink whose credits have not come back yet.
    int outstanding;
    int assert_fails = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !in_credit && !out_valid)
        else begin
            $error("in_credit or out_valid high right after a reset cycle");
            assert_fails++;
        end

    a_valid_has_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> outstanding < OUT_CREDITS)
        else begin
            $error("out_valid fired with no output credit left");
            assert_fails++;
        end

    a_outstanding_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= OUT_CREDITS)
        else begin
            $error("more results outstanding than output credits");
            assert_fails++;
        end

    a_digit_range: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_digit < 4'd10)
        else begin
            $error("out_digit is not a decimal digit");
            assert_fails++;
        end

endmodule

//--- verif/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst,
    input  logic rst_req
);

    timeunit 1ns;
    timeprecision 1ps;

    logic por;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Power-on reset covers the first rising edges and drops on a falling edge.
    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        por = 1'b0;
    end

    assign rst = por | rst_req;

endmodule

//--- rtl/digit_predictor.sv
module digit_predictor
    import digit_pkg::*;
#(
    parameter int HID_DEPTH   = 2,
    parameter int SCORE_DEPTH = 2,
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [IN_SIDE*IN_SIDE-1:0] in_image,
    output logic                       in_credit,
    output logic                       out_valid,
    output logic [3:0]                 out_digit,
    input  logic                       out_credit
);

    logic             scl_valid;
    logic [N_PIX-1:0] scl_image;
    logic             scl_taken;

    logic       hid_valid;
    hid_vec_t   hid_vec;
    logic       hid_credit;
    logic       hid_ready;
    hid_vec_t   hid_head;
    logic       hid_pop;

    logic       score_valid;
    score_vec_t score_vec;
    logic       score_credit;
    logic       score_ready;
    score_vec_t score_head;
    logic       score_pop;

    image_scaler i_scaler (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_image  (in_image),
        .in_credit (in_credit),
        .scl_valid (scl_valid),
        .scl_image (scl_image),
        .scl_taken (scl_taken)
    );

    dense_hidden #(.HID_DEPTH(HID_DEPTH)) i_hidden (
        .clk        (clk),
        .rst        (rst),
        .scl_valid  (scl_valid),
        .scl_image  (scl_image),
        .scl_taken  (scl_taken),
        .hid_valid  (hid_valid),
        .hid_vec    (hid_vec),
        .hid_credit (hid_credit)
    );

    credit_queue #(.payload_t(hid_vec_t), .DEPTH(HID_DEPTH)) i_hid_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (hid_valid),
        .push_data (hid_vec),
        .pop       (hid_pop),
        .pop_data  (hid_head),
        .not_empty (hid_ready),
        .credit    (hid_credit)
    );

    dense_output #(.SCORE_DEPTH(SCORE_DEPTH)) i_output (
        .clk          (clk),
        .rst          (rst),
        .hid_ready    (hid_ready),
        .hid_vec      (hid_head),
        .hid_pop      (hid_pop),
        .score_valid  (score_valid),
        .score_vec    (score_vec),
        .score_credit (score_credit)
    );

    credit_queue #(.payload_t(score_vec_t), .DEPTH(SCORE_DEPTH)) i_score_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (score_valid),
        .push_data (score_vec),
        .pop       (score_pop),
        .pop_data  (score_head),
        .not_empty (score_ready),
        .credit    (score_credit)
    );

    argmax_select #(.OUT_CREDITS(OUT_CREDITS)) i_argmax (
        .clk         (clk),
        .rst         (rst),
        .score_ready (score_ready),
        .score_vec   (score_head),
        .score_pop   (score_pop),
        .out_valid   (out_valid),
        .out_digit   (out_digit),
        .out_credit  (out_credit)
    );

endmodule

//--- rtl/argmax_select.sv
module argmax_select
    import digit_pkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       score_ready,
    input  score_vec_t score_vec,
    output logic       score_pop,
    output logic       out_valid,
    output logic [3:0] out_digit,
    input  logic       out_credit
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credits;
    logic [3:0]    best_idx;
    score_t        best_val;

    assign score_pop = score_ready && (credits != '0);

    // Strict comparison keeps the lowest index on a tie.
    always_comb begin
        best_idx = 4'd0;
        best_val = score_vec[0];
        for (int d = 1; d < N_OUT; d++) begin
            if (score_vec[d] > best_val) begin
                best_idx = 4'(d);
                best_val = score_vec[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (score_pop) begin
            out_digit <= best_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            credits   <= CW'(OUT_CREDITS);
        end else begin
            out_valid <= score_pop;
            credits   <= credits - CW'(score_pop) + CW'(out_credit);
        end
    end

endmodule

//--- rtl/dense_output.sv
module dense_output
    import digit_pkg::*;
#(
    parameter int SCORE_DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hid_ready,
    input  hid_vec_t   hid_vec,
    output logic       hid_pop,
    output logic       score_valid,
    output score_vec_t score_vec,
    input  logic       score_credit
);

    localparam int CW = $clog2(SCORE_DEPTH + 1);

    logic          busy;
    logic [5:0]    nrn_cnt;
    logic [CW-1:0] credits;
    hid_vec_t      hreg;
    score_vec_t    acc;
    score_vec_t    add;
    logic [5:0]    cur_idx;
    hidden_t       cur_h;
    hidden_t       cur_relu;

    assign hid_pop = hid_ready && !busy && (credits != '0);

    // Neuron 0 is taken from the queue head on the pop cycle itself.
    assign cur_idx  = busy ? nrn_cnt : 6'd0;
    assign cur_h    = busy ? hreg[nrn_cnt] : hid_vec[0];
    assign cur_relu = cur_h[15] ? hidden_t'(0) : cur_h;
    assign score_vec = acc;

    always_comb begin
        for (int d = 0; d < N_OUT; d++) begin
            add[d] = score_t'(w_output(d, int'(cur_idx))) * score_t'(cur_relu);
        end
    end

    always_ff @(posedge clk) begin
        if (hid_pop) begin
            hreg <= hid_vec;
        end
        if (hid_pop || busy) begin
            for (int d = 0; d < N_OUT; d++) begin
                acc[d] <= busy ? acc[d] + add[d] : add[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            nrn_cnt     <= '0;
            score_valid <= 1'b0;
            credits     <= CW'(SCORE_DEPTH);
        end else begin
            score_valid <= 1'b0;
            if (hid_pop) begin
                busy    <= 1'b1;
                nrn_cnt <= 6'd1;
            end else if (busy) begin
                if (nrn_cnt == 6'(N_HID - 1)) begin
                    busy        <= 1'b0;
                    score_valid <= 1'b1;
                end else begin
                    nrn_cnt <= nrn_cnt + 6'd1;
                end
            end
            credits <= credits - CW'(hid_pop) + CW'(score_credit);
        end
    end

endmodule

//--- rtl/dense_hidden.sv
module dense_hidden
    import digit_pkg::*;
#(
    parameter int HID_DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             scl_valid,
    input  logic [N_PIX-1:0] scl_image,
    output logic             scl_taken,
    output logic             hid_valid,
    output hid_vec_t         hid_vec,
    input  logic             hid_credit
);

    localparam int CW = $clog2(HID_DEPTH + 1);

    logic             busy;
    logic [9:0]       pix_cnt;
    logic [CW-1:0]    credits;
    logic [N_PIX-1:0] img;
    hid_vec_t         acc;
    hid_vec_t         add;
    logic [9:0]       cur_idx;
    logic             cur_bit;

    // A credit is reserved when the image is taken, so the later push always has room.
    assign scl_taken = scl_valid && !busy && (credits != '0);

    // Pixel 0 is summed on the take cycle straight from the scaler.
    assign cur_idx = busy ? pix_cnt : 10'd0;
    assign cur_bit = busy ? img[pix_cnt] : scl_image[0];
    assign hid_vec = acc;

    always_comb begin
        for (int n = 0; n < N_HID; n++) begin
            add[n] = cur_bit ? hidden_t'(w_hidden(n, int'(cur_idx))) : hidden_t'(0);
        end
    end

    always_ff @(posedge clk) begin
        if (scl_taken) begin
            img <= scl_image;
        end
        if (scl_taken || busy) begin
            for (int n = 0; n < N_HID; n++) begin
                acc[n] <= busy ? acc[n] + add[n] : add[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            pix_cnt   <= '0;
            hid_valid <= 1'b0;
            credits   <= CW'(HID_DEPTH);
        end else begin
            hid_valid <= 1'b0;
            if (scl_taken) begin
                busy    <= 1'b1;
                pix_cnt <= 10'd1;
            end else if (busy) begin
                if (pix_cnt == 10'(N_PIX - 1)) begin
                    busy      <= 1'b0;
                    hid_valid <= 1'b1;
                end else begin
                    pix_cnt <= pix_cnt + 10'd1;
                end
            end
            credits <= credits - CW'(scl_taken) + CW'(hid_credit);
        end
    end

endmodule

//--- rtl/credit_queue.sv
module credit_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Show-ahead read: the head entry is always on pop_data.
    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

endmodule

//--- rtl/image_scaler.sv
module image_scaler
    import digit_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [IN_SIDE*IN_SIDE-1:0] in_image,
    output logic                       in_credit,
    output logic                       scl_valid,
    output logic [N_PIX-1:0]           scl_image,
    input  logic                       scl_taken
);

    logic [N_PIX-1:0] sampled;
    logic             cap_pend;

    always_comb begin
        for (int r = 0; r < OUT_SIDE; r++) begin
            for (int c = 0; c < OUT_SIDE; c++) begin
                sampled[r*OUT_SIDE + c] = in_image[src_index(r)*IN_SIDE + src_index(c)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            scl_image <= sampled;
        end
    end

    // The slot is marked full one cycle after the capture edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_pend  <= 1'b0;
            scl_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            cap_pend  <= in_valid;
            in_credit <= scl_taken & scl_valid;
            if (cap_pend) begin
                scl_valid <= 1'b1;
            end else if (scl_taken) begin
                scl_valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/digit_pkg.sv
package digit_pkg;

    localparam int IN_SIDE  = 52;
    localparam int OUT_SIDE = 28;
    localparam int N_PIX    = OUT_SIDE * OUT_SIDE;
    localparam int N_HID    = 64;
    localparam int N_OUT    = 10;

    typedef logic signed [15:0] hidden_t;
    typedef hidden_t [N_HID-1:0] hid_vec_t;

    typedef logic signed [31:0] score_t;
    typedef score_t [N_OUT-1:0] score_vec_t;

    // Nearest-neighbour sampling: scaled coordinate c reads source coordinate c*52/28.
    function automatic int src_index(input int c);
        return (c * IN_SIDE) / OUT_SIDE;
    endfunction

    // Integer mixing hash, shared by both weight tables.
    function automatic logic [31:0] mix_hash(input int a, input int b, input logic [31:0] salt);
        logic [31:0] h;
        h = salt ^ (32'(a) * 32'h9e37_79b1) ^ (32'(b) * 32'h85eb_ca6b);
        h = h ^ (h >> 15);
        h = h * 32'h2c1b_3c6d;
        h = h ^ (h >> 12);
        h = h * 32'h297a_2d39;
        h = h ^ (h >> 15);
        return h;
    endfunction

    // Hidden weights span -8 to 7, so 784 of them stay inside 16 bits.
    function automatic logic signed [3:0] w_hidden(input int neuron, input int pixel);
        logic [31:0] h;
        h = mix_hash(neuron, pixel, 32'h1b87_3593);
        return h[31:28];
    endfunction

    function automatic logic signed [7:0] w_output(input int digit, input int neuron);
        logic [31:0] h;
        h = mix_hash(digit, neuron, 32'hcc9e_2d51);
        return h[31:24];
    endfunction

endpackage
